//--- hw/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    typedef logic [10:0] mem_addr_t;  // byte address, 2048 locations
    typedef logic [7:0]  mem_data_t;
    typedef logic [3:0]  dev_id_t;    // top nibble of the control byte

    localparam dev_id_t DEFAULT_DEV_ID = 4'b1010;

    // a start issued while the bus is held becomes a repeated start
    typedef enum logic [1:0]
    {
        CMD_START,
        CMD_STOP,
        CMD_WRITE,
        CMD_READ
    } bus_cmd_t;

    typedef enum logic [3:0]
    {
        TXN_IDLE,
        TXN_START,
        TXN_CTRL_WR,
        TXN_ADDR,
        TXN_DATA,
        TXN_RESTART,
        TXN_CTRL_RD,
        TXN_READ,
        TXN_STOP
    } txn_state_t;

endpackage

`default_nettype wire

//--- hw/twi_bit_engine.sv
`timescale 1ns/1ps
`default_nettype none

module twi_bit_engine
(
    input  wire                        CLK,
    input  wire                        RESET,
    input  wire eeprom_pkg::bus_cmd_t  cmd,
    input  wire                        cmd_valid,
    input  wire eeprom_pkg::mem_data_t tx_byte,
    input  wire                        sda_in,
    output logic                       cmd_done,
    output eeprom_pkg::mem_data_t      rx_byte,
    output logic                       scl,
    output logic                       sda_out,
    output logic                       sda_oe
);

    typedef enum logic [2:0]
    {
        ENG_IDLE,
        ENG_START_RISE,
        ENG_START_FALL,
        ENG_START_END,
        ENG_BIT_HIGH,
        ENG_BIT_LOW,
        ENG_STOP_RISE,
        ENG_STOP_END
    } eng_state_t;

    eng_state_t            state;
    logic                  scl_q;    // level scl takes at the next falling CLK edge
    logic                  rd_mode;
    logic [2:0]            bit_cnt;
    eeprom_pkg::mem_data_t tx_sr;
    eeprom_pkg::mem_data_t rx_sr;

    assign rx_byte = rx_sr;

    // scl lags the data line by half a CLK cycle,
    // so data always settles in the middle of a low phase
    always_ff @(negedge CLK)
    begin
        if (RESET)
            scl <= 1'b1;
        else
            scl <= scl_q;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= ENG_IDLE;
            scl_q    <= 1'b1;
            sda_out  <= 1'b1;
            sda_oe   <= 1'b0;
            rd_mode  <= 1'b0;
            bit_cnt  <= '0;
            cmd_done <= 1'b0;
        end
        else
        begin
            cmd_done <= 1'b0;
            case (state)
                ENG_IDLE:
                begin
                    if (cmd_valid)
                    begin
                        case (cmd)
                            eeprom_pkg::CMD_START:
                            begin
                                sda_oe <= 1'b0;  // line floats high while scl is low
                                state  <= ENG_START_RISE;
                            end
                            eeprom_pkg::CMD_STOP:
                            begin
                                sda_oe  <= 1'b1;
                                sda_out <= 1'b0;
                                state   <= ENG_STOP_RISE;
                            end
                            default:
                            begin
                                rd_mode <= (cmd == eeprom_pkg::CMD_READ);
                                bit_cnt <= '0;
                                state   <= ENG_BIT_HIGH;
                            end
                        endcase
                    end
                end
                ENG_START_RISE:
                begin
                    scl_q <= 1'b1;
                    state <= ENG_START_FALL;
                end
                ENG_START_FALL:
                begin
                    sda_oe  <= 1'b1;  // data falls with scl high
                    sda_out <= 1'b0;
                    state   <= ENG_START_END;
                end
                ENG_START_END:
                begin
                    scl_q    <= 1'b0;
                    cmd_done <= 1'b1;
                    state    <= ENG_IDLE;
                end
                ENG_BIT_HIGH:
                begin
                    scl_q <= 1'b1;
                    if (rd_mode)
                    begin
                        sda_oe <= 1'b0;
                    end
                    else
                    begin
                        sda_oe  <= 1'b1;
                        sda_out <= tx_sr[7];  // msb first
                    end
                    state <= ENG_BIT_LOW;
                end
                ENG_BIT_LOW:
                begin
                    scl_q <= 1'b0;
                    if (bit_cnt == 3'd7)
                    begin
                        cmd_done <= 1'b1;
                        state    <= ENG_IDLE;
                    end
                    else
                    begin
                        bit_cnt <= bit_cnt + 3'd1;
                        state   <= ENG_BIT_HIGH;
                    end
                end
                ENG_STOP_RISE:
                begin
                    scl_q <= 1'b1;
                    state <= ENG_STOP_END;
                end
                ENG_STOP_END:
                begin
                    sda_oe   <= 1'b0;  // pull-up raises data, scl stays high
                    cmd_done <= 1'b1;
                    state    <= ENG_IDLE;
                end
                default:
                    state <= ENG_IDLE;
            endcase
        end
    end

    // scl is high in BIT_LOW, so that is where the sample is taken
    always_ff @(posedge CLK)
    begin
        if (state == ENG_IDLE && cmd_valid)
            tx_sr <= tx_byte;
        else if (state == ENG_BIT_LOW && !rd_mode)
            tx_sr <= {tx_sr[6:0], 1'b0};

        if (state == ENG_BIT_LOW && rd_mode)
            rx_sr <= {rx_sr[6:0], sda_in};
    end

endmodule

`default_nettype wire

//--- hw/eeprom_txn_seq.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_txn_seq
#(
    parameter eeprom_pkg::dev_id_t DEV_ID = eeprom_pkg::DEFAULT_DEV_ID
)
(
    input  wire                         CLK,
    input  wire                         RESET,
    input  wire                         wr_req,
    input  wire                         rd_req,
    input  wire eeprom_pkg::mem_addr_t  addr,
    input  wire eeprom_pkg::mem_data_t  wr_data,
    input  wire                         cmd_done,
    input  wire eeprom_pkg::mem_data_t  rx_byte,
    output logic                        busy,
    output logic                        done,
    output eeprom_pkg::mem_data_t       rd_data,
    output eeprom_pkg::bus_cmd_t        cmd,
    output logic                        cmd_valid,
    output eeprom_pkg::mem_data_t       tx_byte
);

    eeprom_pkg::txn_state_t state;
    eeprom_pkg::txn_state_t state_nxt;
    logic                   is_rd;
    eeprom_pkg::mem_addr_t  addr_q;
    eeprom_pkg::mem_data_t  data_q;

    assign busy = (state != eeprom_pkg::TXN_IDLE);

    // successor of each step once the engine reports cmd_done
    always_comb
    begin
        case (state)
            eeprom_pkg::TXN_START:   state_nxt = eeprom_pkg::TXN_CTRL_WR;
            eeprom_pkg::TXN_CTRL_WR: state_nxt = eeprom_pkg::TXN_ADDR;
            eeprom_pkg::TXN_ADDR:
            begin
                if (is_rd)
                    state_nxt = eeprom_pkg::TXN_RESTART;
                else
                    state_nxt = eeprom_pkg::TXN_DATA;
            end
            eeprom_pkg::TXN_DATA:    state_nxt = eeprom_pkg::TXN_STOP;
            eeprom_pkg::TXN_RESTART: state_nxt = eeprom_pkg::TXN_CTRL_RD;
            eeprom_pkg::TXN_CTRL_RD: state_nxt = eeprom_pkg::TXN_READ;
            eeprom_pkg::TXN_READ:    state_nxt = eeprom_pkg::TXN_STOP;
            default:                 state_nxt = eeprom_pkg::TXN_IDLE;
        endcase
    end

    // one engine command per state, held steady for the whole step
    always_comb
    begin
        case (state)
            eeprom_pkg::TXN_START,
            eeprom_pkg::TXN_RESTART: cmd = eeprom_pkg::CMD_START;
            eeprom_pkg::TXN_READ:    cmd = eeprom_pkg::CMD_READ;
            eeprom_pkg::TXN_CTRL_WR,
            eeprom_pkg::TXN_ADDR,
            eeprom_pkg::TXN_DATA,
            eeprom_pkg::TXN_CTRL_RD: cmd = eeprom_pkg::CMD_WRITE;
            default:                 cmd = eeprom_pkg::CMD_STOP;
        endcase
    end

    always_comb
    begin
        case (state)
            eeprom_pkg::TXN_CTRL_WR: tx_byte = {DEV_ID, addr_q[10:8], 1'b0};
            eeprom_pkg::TXN_CTRL_RD: tx_byte = {DEV_ID, addr_q[10:8], 1'b1};
            eeprom_pkg::TXN_ADDR:    tx_byte = addr_q[7:0];  // low address byte
            default:                 tx_byte = data_q;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= eeprom_pkg::TXN_IDLE;
            is_rd     <= 1'b0;
            cmd_valid <= 1'b0;
            done      <= 1'b0;
        end
        else
        begin
            cmd_valid <= 1'b0;
            done      <= 1'b0;
            if (state == eeprom_pkg::TXN_IDLE)
            begin
                if (wr_req || rd_req)
                begin
                    is_rd     <= rd_req && !wr_req;  // write wins a tie
                    cmd_valid <= 1'b1;
                    state     <= eeprom_pkg::TXN_START;
                end
            end
            else if (cmd_done)
            begin
                state <= state_nxt;
                if (state == eeprom_pkg::TXN_STOP)
                    done <= 1'b1;
                else
                    cmd_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == eeprom_pkg::TXN_IDLE && (wr_req || rd_req))
        begin
            addr_q <= addr;
            data_q <= wr_data;
        end

        // engine keeps the received byte through the stop
        if (state == eeprom_pkg::TXN_STOP && cmd_done && is_rd)
            rd_data <= rx_byte;
    end

endmodule

`default_nettype wire

//--- hw/eeprom_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

// sequencer walks eeprom_pkg::txn_state_t, one bus command per step
module eeprom_ctrl_top
#(
    parameter eeprom_pkg::dev_id_t DEV_ID = eeprom_pkg::DEFAULT_DEV_ID
)
(
    input  wire                         CLK,
    input  wire                         RESET,
    input  wire                         wr_req,
    input  wire                         rd_req,
    input  wire eeprom_pkg::mem_addr_t  addr,
    input  wire eeprom_pkg::mem_data_t  wr_data,
    output logic                        busy,
    output logic                        done,
    output eeprom_pkg::mem_data_t       rd_data,
    output logic                        scl,
    output logic                        sda_out,
    output logic                        sda_oe,
    input  wire                         sda_in
);

    eeprom_pkg::bus_cmd_t  cmd;
    logic                  cmd_valid;
    logic                  cmd_done;
    eeprom_pkg::mem_data_t tx_byte;
    eeprom_pkg::mem_data_t rx_byte;

    eeprom_txn_seq
    #(
        .DEV_ID (DEV_ID)
    )
    seq_i
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr_req    (wr_req),
        .rd_req    (rd_req),
        .addr      (addr),
        .wr_data   (wr_data),
        .cmd_done  (cmd_done),
        .rx_byte   (rx_byte),
        .busy      (busy),
        .done      (done),
        .rd_data   (rd_data),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .tx_byte   (tx_byte)
    );

    twi_bit_engine engine_i
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .tx_byte   (tx_byte),
        .sda_in    (sda_in),
        .cmd_done  (cmd_done),
        .rx_byte   (rx_byte),
        .scl       (scl),
        .sda_out   (sda_out),
        .sda_oe    (sda_oe)
    );

endmodule

`default_nettype wire

//--- dv/eeprom_bus_model.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_bus_model
(
    input  wire  scl,
    input  wire  sda,
    output logic drive_en,
    output logic drive_val
);

    eeprom_pkg::mem_data_t mem [2048];
    eeprom_pkg::mem_data_t sr;
    eeprom_pkg::mem_addr_t ptr;
    logic [2:0]            page;
    logic                  in_frame = 1'b0;
    logic                  restart;
    logic                  frame_ok;
    logic                  send_pending = 1'b0;
    logic                  sending = 1'b0;
    int                    bit_cnt;
    int                    byte_cnt;
    int                    send_cnt;
    int                    wr_frames = 0;
    int                    rd_frames = 0;
    int                    bad_frames = 0;

    initial
    begin
        drive_en  = 1'b0;
        drive_val = 1'b1;
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hFF;
    end

    // start or repeated start: data falls while scl high
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            restart  = in_frame;
            if (in_frame && byte_cnt != 2)
                frame_ok = 1'b0;  // restart only after control and address
            if (!in_frame)
                frame_ok = 1'b1;
            in_frame = 1'b1;
            bit_cnt  = 0;
            byte_cnt = 0;
            send_cnt = 0;
        end
    end

    // stop: data rises while scl high
    always @(posedge sda)
    begin
        if (scl === 1'b1 && in_frame)
        begin
            if (frame_ok && !restart && byte_cnt == 3)
                wr_frames++;
            else if (frame_ok && restart && byte_cnt == 1 && send_cnt == 8)
                rd_frames++;
            else
                bad_frames++;
            in_frame  = 1'b0;
            sending   = 1'b0;
            drive_en  = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (in_frame && sending)
            send_cnt++;
        else if (in_frame)
        begin
            sr = {sr[6:0], sda};
            bit_cnt++;
            if (bit_cnt == 8)
            begin
                bit_cnt = 0;
                if (byte_cnt == 0)
                begin
                    if (sr[7:4] != eeprom_pkg::DEFAULT_DEV_ID || sr[0] != restart)
                        frame_ok = 1'b0;
                    if (restart && sr[3:1] != ptr[10:8])
                        frame_ok = 1'b0;
                    page = sr[3:1];
                    if (restart)
                        send_pending = 1'b1;
                end
                else if (byte_cnt == 1)
                    ptr = {page, sr};
                else if (byte_cnt == 2 && frame_ok)
                    mem[ptr] = sr;
                byte_cnt++;
            end
        end
    end

    // read data changes only while scl is low
    always @(negedge scl)
    begin
        if (send_pending)
        begin
            send_pending = 1'b0;
            sending      = 1'b1;
            drive_en     = 1'b1;
            drive_val    = mem[ptr][7];
        end
        else if (sending && send_cnt == 8)
        begin
            sending  = 1'b0;
            drive_en = 1'b0;
        end
        else if (sending)
            drive_val = mem[ptr][7 - send_cnt];
    end

endmodule

`default_nettype wire

//--- dv/tb_eeprom_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom_ctrl;

    logic                  CLK = 1'b0;
    logic                  RESET;
    logic                  wr_req;
    logic                  rd_req;
    eeprom_pkg::mem_addr_t addr;
    eeprom_pkg::mem_data_t wr_data;
    logic                  busy;
    logic                  done;
    eeprom_pkg::mem_data_t rd_data;
    logic                  scl;
    logic                  sda_out;
    logic                  sda_oe;
    logic                  model_en;
    logic                  model_val;
    wire                   sda;

    eeprom_pkg::mem_data_t shadow [2048];
    int                    seed = 32'haea1_6e7c;
    int                    err_count = 0;
    int                    pass_tests = 0;
    int                    fail_tests = 0;
    int                    issued = 0;

    assign sda = (sda_oe === 1'b1) ? sda_out : ((model_en === 1'b1) ? model_val : 1'b1);

    always #50 CLK = ~CLK;

    eeprom_ctrl_top dut_i
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr_req  (wr_req),
        .rd_req  (rd_req),
        .addr    (addr),
        .wr_data (wr_data),
        .busy    (busy),
        .done    (done),
        .rd_data (rd_data),
        .scl     (scl),
        .sda_out (sda_out),
        .sda_oe  (sda_oe),
        .sda_in  (sda)
    );

    eeprom_bus_model model_i
    (
        .scl       (scl),
        .sda       (sda),
        .drive_en  (model_en),
        .drive_val (model_val)
    );

    // last byte written, or the erased value
    function automatic eeprom_pkg::mem_data_t expected_read(input eeprom_pkg::mem_addr_t a);
        return shadow[a];
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act)
        begin
            $display("[ERROR] %0d ns %s expected %0h got %0h", $time, name, exp, act);
            err_count++;
        end
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (done !== 1'b1 && cycles <= 400)
        begin
            @(negedge CLK);
            cycles++;
        end
        if (done !== 1'b1)
        begin
            $display("timeout: done never arrived after %0d cycles", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    endtask

    task automatic pulse_request(input logic w, input logic r,
                                 input eeprom_pkg::mem_addr_t a, input eeprom_pkg::mem_data_t d);
        @(negedge CLK);
        wr_req  = w;
        rd_req  = r;
        addr    = a;
        wr_data = d;
        @(negedge CLK);
        wr_req = 1'b0;
        rd_req = 1'b0;
    endtask

    task automatic write_byte(input eeprom_pkg::mem_addr_t a, input eeprom_pkg::mem_data_t d);
        pulse_request(1'b1, 1'b0, a, d);
        shadow[a] = d;
        issued++;
        wait_done();
    endtask

    task automatic read_and_check(input eeprom_pkg::mem_addr_t a);
        pulse_request(1'b0, 1'b1, a, 8'h00);
        issued++;
        wait_done();
        check_value("rd_data", 32'(expected_read(a)), 32'(rd_data));
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_count == errs_before)
        begin
            pass_tests++;
            $display("test %s: pass", name);
        end
        else
        begin
            fail_tests++;
            $display("test %s: fail", name);
        end
    endtask

    initial
    begin
        int                    errs;
        int                    wr_before;
        int                    rd_before;
        eeprom_pkg::mem_addr_t a;
        eeprom_pkg::mem_data_t d;
        eeprom_pkg::mem_data_t lo;

        for (int i = 0; i < 2048; i++)
            shadow[i] = 8'hFF;
        RESET   = 1'b1;
        wr_req  = 1'b0;
        rd_req  = 1'b0;
        addr    = '0;
        wr_data = '0;
        repeat (16) @(negedge CLK);
        RESET = 1'b0;

        errs = err_count;
        @(posedge CLK);  // scl moves on the falling edge
        check_value("scl", 1, 32'(scl));
        check_value("sda_oe", 0, 32'(sda_oe));
        check_value("busy", 0, 32'(busy));
        check_value("done", 0, 32'(done));
        finish_test("reset_state", errs);

        errs = err_count;
        write_byte(11'h2A5, 8'h3C);
        read_and_check(11'h2A5);
        finish_test("write_then_read", errs);

        errs = err_count;
        for (int i = 0; i < 40; i++)
        begin
            if (i % 8 == 0)
                lo = 8'($random(seed));  // same low byte on all eight pages
            a = {i[2:0], lo};
            d = 8'($random(seed));
            write_byte(a, d);
            if (i % 8 == 7)
            begin
                for (int p = 0; p < 8; p++)
                    read_and_check({p[2:0], lo});
            end
            if (i % 5 == 0)
                read_and_check(11'($random(seed)));
        end
        finish_test("random_pages", errs);

        errs = err_count;
        wr_before = model_i.wr_frames;
        pulse_request(1'b1, 1'b0, 11'h011, 8'h5A);
        shadow[11'h011] = 8'h5A;
        issued++;
        repeat (3) @(negedge CLK);
        check_value("busy", 1, 32'(busy));
        pulse_request(1'b1, 1'b0, 11'h2A5, 8'hC3);  // must be dropped
        wait_done();
        check_value("wr_frames", wr_before + 1, model_i.wr_frames);
        read_and_check(11'h2A5);
        finish_test("request_while_busy", errs);

        errs = err_count;
        wr_before = model_i.wr_frames;
        rd_before = model_i.rd_frames;
        pulse_request(1'b1, 1'b1, 11'h7F0, 8'h96);
        shadow[11'h7F0] = 8'h96;
        issued++;
        wait_done();
        check_value("wr_frames", wr_before + 1, model_i.wr_frames);
        check_value("rd_frames", rd_before, model_i.rd_frames);
        read_and_check(11'h7F0);
        finish_test("write_wins_tie", errs);

        errs = err_count;
        repeat (4) @(negedge CLK);
        check_value("frames", issued, model_i.wr_frames + model_i.rd_frames);
        check_value("bad_frames", 0, model_i.bad_frames);
        finish_test("frame_count", errs);

        $display("tests passed %0d, failed %0d", pass_tests, fail_tests);
        if (fail_tests == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
hw/eeprom_pkg.sv
hw/twi_bit_engine.sv
hw/eeprom_txn_seq.sv
hw/eeprom_ctrl_top.sv
dv/eeprom_bus_model.sv
dv/tb_eeprom_ctrl.sv

//--- Makefile
VERILATOR  ?= verilator
FLAGS      ?= --timing
TOP        ?= tb_eeprom_ctrl
RTL_TOP    ?= eeprom_ctrl_top
FILELIST   ?= src.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := ALL TESTS PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
